// ==== files.f ====
+incdir+rtl
rtl/safe_pkg.sv
rtl/safe_rstgen.sv
rtl/slow_clk_gen.sv
rtl/padcfg_regs.sv
rtl/pad_control.sv
rtl/safe_domain.sv
tb/tb_safe_domain.sv

// ==== run.sh ====
#!/bin/sh
# build and run the safe domain testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -f files.f --top-module tb_safe_domain \
  -Mdir "$BUILD_DIR" -o sim_safe_domain > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "build failed"
  exit 1
fi

"./$BUILD_DIR/sim_safe_domain" > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "TB FAILED" "$SIM_LOG"; then
  echo "simulation reported failure"
  exit 1
fi

exit 0

// ==== tb/tb_safe_domain.sv ====
// Testbench for the safe domain top, on a 10 ns reference clock.
// Inputs change on the rising edge and outputs are sampled on the falling edge.
// The model follows credit_o pulses in write order, so it assumes that
// every write the testbench sends is eventually applied.
`timescale 1ns/100ps
`default_nettype none
`include "safe_params.svh"

module tb_safe_domain;

  import safe_pkg::*;

  localparam int N        = `SAFE_N_IO;
  localparam int PAD_W    = $clog2(`SAFE_N_IO);
  localparam int WAIT_MAX = 40 * `SAFE_SLOW_DIV;
  localparam int N_TBL    = 8;

  // *********************************************************
  // stimulus table with one single write per row
  // *********************************************************

  localparam int       TBL_PAD [N_TBL] = '{3, 5, 0, 15, 7, 3, 8, 12};
  localparam pad_src_e TBL_SEL [N_TBL] = '{PAD_SRC_APBIO, PAD_SRC_FPGAIO, PAD_SRC_OFF,
    PAD_SRC_APBIO, PAD_SRC_FPGAIO, PAD_SRC_OFF, PAD_SRC_APBIO, PAD_SRC_PERIO};
  // burst rows where pad 2 is written twice and must end up off
  localparam int       BURST_PAD [`SAFE_PADCFG_CREDITS] = '{2, 9, 2, 14};
  localparam pad_src_e BURST_SEL [`SAFE_PADCFG_CREDITS] = '{PAD_SRC_APBIO,
    PAD_SRC_FPGAIO, PAD_SRC_OFF, PAD_SRC_APBIO};

  logic ref_clk_i;
  logic reset_i;
  logic rst_o;
  logic slow_clk_o;
  logic credit_o;
  padcfg_wr_t padcfg_wr_i;
  pad_bank_t  perio_i;
  pad_bank_t  apbio_i;
  pad_bank_t  fpgaio_i;
  logic [N-1:0] io_in_i;
  logic [N-1:0] io_out_o;
  logic [N-1:0] io_oe_o;
  logic [N-1:0] perio_in_o;
  logic [N-1:0] apbio_in_o;
  logic [N-1:0] fpgaio_in_o;

  // bank patterns per table row from the seeded generator
  pad_bank_t    tbl_perio [N_TBL];
  pad_bank_t    tbl_apbio [N_TBL];
  pad_bank_t    tbl_fpgaio [N_TBL];
  logic [N-1:0] tbl_io_in [N_TBL];

  int seed = 32'h6eccf09c;
  int errors = 0;
  int mon_errors = 0;
  int checks = 0;
  // writes sent by the main flow and credits seen by the monitor
  int sent = 0;
  int credit_seen = 0;
  int target;
  padcfg_wr_t sent_wr [32];
  pad_src_e   model_sel [N];

  safe_domain i_safe_domain (
    .ref_clk_i   (ref_clk_i),
    .reset_i     (reset_i),
    .rst_o       (rst_o),
    .slow_clk_o  (slow_clk_o),
    .padcfg_wr_i (padcfg_wr_i),
    .credit_o    (credit_o),
    .perio_i     (perio_i),
    .apbio_i     (apbio_i),
    .fpgaio_i    (fpgaio_i),
    .io_in_i     (io_in_i),
    .io_out_o    (io_out_o),
    .io_oe_o     (io_oe_o),
    .perio_in_o  (perio_in_o),
    .apbio_in_o  (apbio_in_o),
    .fpgaio_in_o (fpgaio_in_o)
  );

  initial begin
    ref_clk_i = 1'b0;
    forever #5 ref_clk_i = ~ref_clk_i;
  end

  // each credit pulse applies the oldest outstanding write to the model
  always @(negedge ref_clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < N; i++) begin
        model_sel[i] = PAD_SRC_PERIO;
      end
    end else if (credit_o) begin
      if (credit_seen >= sent) begin
        mon_errors++;
        $display("credit_o pulse at %0t with no write outstanding", $time);
      end else begin
        model_sel[sent_wr[credit_seen].pad] = sent_wr[credit_seen].sel;
      end
      credit_seen++;
    end
  end

  function automatic logic [N-1:0] rand_bits();
    logic [31:0] r;
    r = $random(seed);
    return r[N-1:0];
  endfunction

  // pads whose model selection is src
  function automatic logic [N-1:0] sel_mask(input pad_src_e src);
    logic [N-1:0] m;
    m = '0;
    for (int i = 0; i < N; i++) begin
      m[i] = (model_sel[i] == src);
    end
    return m;
  endfunction

  task automatic check_bits(input string name, input logic [N-1:0] exp, input logic [N-1:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("MISMATCH t=%0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_int(input string name, input int exp, input int act);
    checks++;
    if (exp != act) begin
      errors++;
      $display("MISMATCH t=%0t %s expected %0d actual %0d", $time, name, exp, act);
    end
  endtask

  // pad outputs and bank inputs against the model masks
  task automatic check_pads();
    logic [N-1:0] m_p;
    logic [N-1:0] m_a;
    logic [N-1:0] m_f;
    logic [N-1:0] m_off;
    m_p   = sel_mask(PAD_SRC_PERIO);
    m_a   = sel_mask(PAD_SRC_APBIO);
    m_f   = sel_mask(PAD_SRC_FPGAIO);
    m_off = sel_mask(PAD_SRC_OFF);
    check_bits("io_out_o", (perio_i.out & m_p) | (apbio_i.out & m_a) | (fpgaio_i.out & m_f),
      io_out_o);
    check_bits("io_oe_o", (perio_i.oe & m_p) | (apbio_i.oe & m_a) | (fpgaio_i.oe & m_f),
      io_oe_o);
    check_bits("perio_in_o", io_in_i & m_p, perio_in_o);
    check_bits("apbio_in_o", io_in_i & m_a, apbio_in_o);
    check_bits("fpgaio_in_o", io_in_i & m_f, fpgaio_in_o);
    check_bits("io_oe_o on off pads", '0, io_oe_o & m_off);
  endtask

  // caller sits on a rising edge and spends one credit per valid cycle
  task automatic send_write(input int pad, input pad_src_e sel);
    padcfg_wr_t w;
    w.valid = 1'b1;
    w.pad   = PAD_W'(pad);
    w.sel   = sel;
    if (sent - credit_seen >= `SAFE_PADCFG_CREDITS) begin
      errors++;
      $display("no credit left for a write at %0t", $time);
    end else begin
      padcfg_wr_i <= w;
      sent_wr[sent] = w;
      sent++;
    end
  endtask

  task automatic end_writes();
    @(posedge ref_clk_i);
    padcfg_wr_i <= '0;
  endtask

  task automatic wait_credits(input int total);
    int n;
    n = 0;
    while (credit_seen < total && n < WAIT_MAX) begin
      @(posedge ref_clk_i);
      n++;
    end
    if (credit_seen < total) begin
      errors++;
      $display("timeout at %0t waiting for credit_o, saw %0d of %0d", $time, credit_seen, total);
    end
  endtask

  // count edges from release until rst_o drops
  task automatic check_reset_hold();
    int   edges;
    logic done;
    edges = 0;
    done  = 1'b0;
    while (!done && edges < WAIT_MAX) begin
      @(posedge ref_clk_i);
      edges++;
      @(negedge ref_clk_i);
      done = !rst_o;
    end
    if (!done) begin
      errors++;
      $display("timeout at %0t, rst_o never dropped after reset release", $time);
    end else begin
      check_int("rst_o hold edges", `SAFE_RST_HOLD, edges);
    end
  endtask

  // ref cycles between two rising slow clock edges
  task automatic check_slow_period();
    int   n;
    int   rises;
    int   start;
    logic prev;
    n     = 0;
    rises = 0;
    start = 0;
    @(negedge ref_clk_i);
    prev = slow_clk_o;
    while (rises < 2 && n < WAIT_MAX) begin
      @(negedge ref_clk_i);
      n++;
      if (slow_clk_o && !prev) begin
        rises++;
        if (rises == 1) begin
          start = n;
        end
      end
      prev = slow_clk_o;
    end
    if (rises < 2) begin
      errors++;
      $display("timeout at %0t, slow_clk_o did not rise twice", $time);
    end else begin
      check_int("slow_clk_o period", 2 * `SAFE_SLOW_DIV, n - start);
    end
  endtask

  task automatic fill_table();
    for (int k = 0; k < N_TBL; k++) begin
      tbl_perio[k]  = '{out: rand_bits(), oe: rand_bits()};
      tbl_apbio[k]  = '{out: rand_bits(), oe: rand_bits()};
      tbl_fpgaio[k] = '{out: rand_bits(), oe: rand_bits()};
      tbl_io_in[k]  = rand_bits();
    end
  endtask

  initial begin
    reset_i     = 1'b1;
    padcfg_wr_i = '0;
    perio_i     = '0;
    apbio_i     = '0;
    fpgaio_i    = '0;
    io_in_i     = '0;
    fill_table();

    // ************************************************************
    // reset and clocks
    // ************************************************************
    repeat (3) @(posedge ref_clk_i);
    @(negedge ref_clk_i);
    check_int("rst_o in reset", 1, int'(rst_o));
    @(posedge ref_clk_i);
    reset_i <= 1'b0;
    check_reset_hold();

    // all pads on PERIO before any write
    @(posedge ref_clk_i);
    perio_i  <= '{out: rand_bits(), oe: rand_bits()};
    apbio_i  <= '{out: rand_bits(), oe: rand_bits()};
    fpgaio_i <= '{out: rand_bits(), oe: rand_bits()};
    io_in_i  <= rand_bits();
    @(negedge ref_clk_i);
    check_bits("io_out_o after reset", perio_i.out, io_out_o);
    check_bits("io_oe_o after reset", perio_i.oe, io_oe_o);
    check_pads();
    check_slow_period();

    // ************************************************************
    // single writes from the table
    // ************************************************************
    for (int k = 0; k < N_TBL; k++) begin
      target = credit_seen + 1;
      @(posedge ref_clk_i);
      perio_i  <= tbl_perio[k];
      apbio_i  <= tbl_apbio[k];
      fpgaio_i <= tbl_fpgaio[k];
      io_in_i  <= tbl_io_in[k];
      send_write(TBL_PAD[k], TBL_SEL[k]);
      end_writes();
      wait_credits(target);
      // selection shows one cycle after the credit
      @(negedge ref_clk_i);
      check_pads();
    end

    // ************************************************************
    // burst of back-to-back writes with every oe high
    // ************************************************************
    target = credit_seen + `SAFE_PADCFG_CREDITS;
    for (int b = 0; b < `SAFE_PADCFG_CREDITS; b++) begin
      @(posedge ref_clk_i);
      if (b == 0) begin
        perio_i  <= '{out: rand_bits(), oe: '1};
        apbio_i  <= '{out: rand_bits(), oe: '1};
        fpgaio_i <= '{out: rand_bits(), oe: '1};
        io_in_i  <= rand_bits();
      end
      send_write(BURST_PAD[b], BURST_SEL[b]);
    end
    end_writes();
    wait_credits(target);
    @(negedge ref_clk_i);
    check_pads();
    check_int("io_oe_o pad 2 after second write", 0, int'(io_oe_o[2]));
    // no stray credits once the queue is drained
    repeat (4 * `SAFE_SLOW_DIV) @(posedge ref_clk_i);
    check_int("credit_o pulses", target, credit_seen);
    check_int("credits held", `SAFE_PADCFG_CREDITS, `SAFE_PADCFG_CREDITS - sent + credit_seen);

    $display("checks %0d, errors %0d", checks, errors + mon_errors);
    if (errors + mon_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== rtl/safe_domain.sv ====
// Always-on safe domain top, everything runs on ref_clk_i.
// The slow clock and the config block start from reset_i, so the first
// slow tick lands SAFE_SLOW_DIV cycles after release; rst_o is the
// stretched reset handed to the rest of the chip.
// No FPGA clock path, no DFT outputs, no pad electrical config.
`timescale 1ns/100ps
`default_nettype none
`include "safe_params.svh"

module safe_domain (
  input  logic                  ref_clk_i,
  input  logic                  reset_i,
  output logic                  rst_o,
  output logic                  slow_clk_o,

  // *********************************************************
  // pad config write channel
  // *********************************************************

  input  safe_pkg::padcfg_wr_t  padcfg_wr_i,
  output logic                  credit_o,

  // *********************************************************
  // peripheral banks and pads
  // *********************************************************

  input  safe_pkg::pad_bank_t   perio_i,
  input  safe_pkg::pad_bank_t   apbio_i,
  input  safe_pkg::pad_bank_t   fpgaio_i,
  input  logic [`SAFE_N_IO-1:0] io_in_i,
  output logic [`SAFE_N_IO-1:0] io_out_o,
  output logic [`SAFE_N_IO-1:0] io_oe_o,
  output logic [`SAFE_N_IO-1:0] perio_in_o,
  output logic [`SAFE_N_IO-1:0] apbio_in_o,
  output logic [`SAFE_N_IO-1:0] fpgaio_in_o
);

  import safe_pkg::*;

  // slow tick acts as the config block's clock enable
  logic                      s_slow_tick;
  // current source per pad
  pad_src_e [`SAFE_N_IO-1:0] s_pad_sel;

  // stretched domain reset for downstream logic
  safe_rstgen i_safe_rstgen (
    .ref_clk_i (ref_clk_i),
    .reset_i   (reset_i),
    .rst_o     (rst_o)
  );

  slow_clk_gen i_slow_clk_gen (
    .ref_clk_i   (ref_clk_i),
    .reset_i     (reset_i),
    .slow_clk_o  (slow_clk_o),
    .slow_tick_o (s_slow_tick)
  );

  // queued writes, applied one per slow tick
  padcfg_regs i_padcfg_regs (
    .ref_clk_i   (ref_clk_i),
    .reset_i     (reset_i),
    .slow_tick_i (s_slow_tick),
    .padcfg_wr_i (padcfg_wr_i),
    .credit_o    (credit_o),
    .pad_sel_o   (s_pad_sel)
  );

  pad_control i_pad_control (
    .pad_sel_i   (s_pad_sel),
    .perio_i     (perio_i),
    .apbio_i     (apbio_i),
    .fpgaio_i    (fpgaio_i),
    .io_in_i     (io_in_i),
    .io_out_o    (io_out_o),
    .io_oe_o     (io_oe_o),
    .perio_in_o  (perio_in_o),
    .apbio_in_o  (apbio_in_o),
    .fpgaio_in_o (fpgaio_in_o)
  );

endmodule

`default_nettype wire

// ==== rtl/pad_control.sv ====
// Combinational pad mux between the three peripheral banks.
// Pad i takes out and oe from bit i of its selected bank; an off pad
// drives 0 and 0. Pad inputs go back only to the bank a pad selects,
// all other bank input bits read 0.
`timescale 1ns/100ps
`default_nettype none
`include "safe_params.svh"

module pad_control (
  input  safe_pkg::pad_src_e [`SAFE_N_IO-1:0] pad_sel_i,
  input  safe_pkg::pad_bank_t                 perio_i,
  input  safe_pkg::pad_bank_t                 apbio_i,
  input  safe_pkg::pad_bank_t                 fpgaio_i,
  input  logic [`SAFE_N_IO-1:0]               io_in_i,
  output logic [`SAFE_N_IO-1:0]               io_out_o,
  output logic [`SAFE_N_IO-1:0]               io_oe_o,
  output logic [`SAFE_N_IO-1:0]               perio_in_o,
  output logic [`SAFE_N_IO-1:0]               apbio_in_o,
  output logic [`SAFE_N_IO-1:0]               fpgaio_in_o
);

  import safe_pkg::*;

  // *********************************************************
  // per pad mux and input demux
  // *********************************************************

  always_comb begin
    // everything parked low unless a bank claims the pad
    io_out_o    = '0;
    io_oe_o     = '0;
    perio_in_o  = '0;
    apbio_in_o  = '0;
    fpgaio_in_o = '0;

    for (int i = 0; i < `SAFE_N_IO; i++) begin
      case (pad_sel_i[i])
        PAD_SRC_PERIO: begin
          io_out_o[i]   = perio_i.out[i];
          io_oe_o[i]    = perio_i.oe[i];
          perio_in_o[i] = io_in_i[i];
        end
        PAD_SRC_APBIO: begin
          io_out_o[i]   = apbio_i.out[i];
          io_oe_o[i]    = apbio_i.oe[i];
          apbio_in_o[i] = io_in_i[i];
        end
        PAD_SRC_FPGAIO: begin
          io_out_o[i]    = fpgaio_i.out[i];
          io_oe_o[i]     = fpgaio_i.oe[i];
          fpgaio_in_o[i] = io_in_i[i];
        end
        // off pad keeps the zero defaults
        default: begin
          io_out_o[i] = 1'b0;
          io_oe_o[i]  = 1'b0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/padcfg_regs.sv ====
// Pad mux selection registers behind a credit-flow write queue.
// The sender owns SAFE_PADCFG_CREDITS credits after reset and may raise
// valid only while it holds one; there is no other back-pressure.
// Entries are applied in order, at most one per slow tick, and credit_o
// is high in the cycle the entry is applied. pad_sel_o shows it one later.
`timescale 1ns/100ps
`default_nettype none
`include "safe_params.svh"

module padcfg_regs (
  input  logic                                ref_clk_i,
  input  logic                                reset_i,
  input  logic                                slow_tick_i,
  input  safe_pkg::padcfg_wr_t                padcfg_wr_i,
  output logic                                credit_o,
  output safe_pkg::pad_src_e [`SAFE_N_IO-1:0] pad_sel_o
);

  import safe_pkg::*;

  localparam int unsigned DEPTH = `SAFE_PADCFG_CREDITS;
  localparam int unsigned PTR_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  // *********************************************************
  // write queue
  // *********************************************************

  padcfg_wr_t       queue_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;
  logic             full;
  logic             empty;
  padcfg_wr_t       head;

  // circular pointer step, wraps at DEPTH even when not a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full  = (count_q == CNT_W'(DEPTH));
  assign empty = (count_q == '0);
  assign push  = padcfg_wr_i.valid;
  // one entry per slow tick
  assign pop   = slow_tick_i & ~empty;
  assign head  = queue_q[rd_ptr_q];

  always_ff @(posedge ref_clk_i) begin
    if (push) begin
      queue_q[wr_ptr_q] <= padcfg_wr_i;
    end
  end

  always_ff @(posedge ref_clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      // push and pop in one cycle leave the fill level alone
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // *********************************************************
  // selection registers
  // *********************************************************

  pad_src_e [`SAFE_N_IO-1:0] pad_sel_q;

  always_ff @(posedge ref_clk_i) begin
    if (reset_i) begin
      // all pads start on the PERIO bank
      for (int i = 0; i < `SAFE_N_IO; i++) begin
        pad_sel_q[i] <= PAD_SRC_PERIO;
      end
    end else if (pop) begin
      pad_sel_q[head.pad] <= head.sel;
    end
  end

  assign pad_sel_o = pad_sel_q;

  // the credit goes back in the same cycle the entry leaves the queue
  assign credit_o = pop;

  // *********************************************************
  // checks
  // *********************************************************

  // a sender that keeps to its credits never writes into a full queue
  a_no_overflow : assert property (
    @(posedge ref_clk_i) disable iff (reset_i)
    !(push && full)
  ) else $error("padcfg_regs: write while queue full, credit rule broken");

endmodule

`default_nettype wire

// ==== rtl/slow_clk_gen.sv ====
// Always-on slow clock divided down from the reference clock.
// slow_clk_o is a register output, low in reset, period 2*SAFE_SLOW_DIV.
// slow_tick_o is high for the ref cycle in which slow_clk_o has just risen;
// logic on ref_clk_i should use the tick as an enable, not the slow clock.
`timescale 1ns/100ps
`default_nettype none
`include "safe_params.svh"

module slow_clk_gen (
  input  logic ref_clk_i,
  input  logic reset_i,
  output logic slow_clk_o,
  output logic slow_tick_o
);

  localparam int unsigned DIV   = `SAFE_SLOW_DIV;
  localparam int unsigned CNT_W = $clog2(DIV);

  logic [CNT_W-1:0] div_cnt_q;
  logic             slow_clk_q;
  logic             slow_tick_q;
  logic             wrap;

  // last ref cycle of a half period
  assign wrap = (div_cnt_q == CNT_W'(DIV - 1));

  always_ff @(posedge ref_clk_i) begin
    if (reset_i) begin
      div_cnt_q   <= '0;
      slow_clk_q  <= 1'b0;
      slow_tick_q <= 1'b0;
    end else begin
      // tick lands together with the low-to-high toggle
      slow_tick_q <= wrap & ~slow_clk_q;
      if (wrap) begin
        div_cnt_q  <= '0;
        slow_clk_q <= ~slow_clk_q;
      end else begin
        div_cnt_q <= div_cnt_q + 1'b1;
      end
    end
  end

  assign slow_clk_o  = slow_clk_q;
  assign slow_tick_o = slow_tick_q;

  // *********************************************************
  // checks
  // *********************************************************

  // the tick marks a rising slow edge and nothing else
  a_tick_on_rise : assert property (
    @(posedge ref_clk_i) disable iff (reset_i)
    slow_tick_o |-> $rose(slow_clk_o)
  ) else $error("slow_clk_gen: tick without rising slow clock");

  // rising edges come a full slow period apart
  a_slow_period : assert property (
    @(posedge ref_clk_i) disable iff (reset_i)
    $rose(slow_clk_o) |-> ##(2 * `SAFE_SLOW_DIV) $rose(slow_clk_o)
  ) else $error("slow_clk_gen: slow clock period off");

endmodule

`default_nettype wire

// ==== rtl/safe_rstgen.sv ====
// Domain reset stretcher on the reference clock.
// rst_o follows reset_i high without delay, then drops right after the
// SAFE_RST_HOLD-th rising edge that samples reset_i low.
// A new reset_i during the hold restarts the full hold.
`timescale 1ns/100ps
`default_nettype none
`include "safe_params.svh"

module safe_rstgen (
  input  logic ref_clk_i,
  input  logic reset_i,
  output logic rst_o
);

  localparam int unsigned HOLD  = `SAFE_RST_HOLD;
  localparam int unsigned CNT_W = $clog2(HOLD + 1);

  // edges still to go before the domain reset drops
  logic [CNT_W-1:0] hold_cnt_q;

  // reload while reset_i is up, then count down to zero and park there
  always_ff @(posedge ref_clk_i) begin
    if (reset_i) begin
      hold_cnt_q <= CNT_W'(HOLD);
    end else if (hold_cnt_q != '0) begin
      hold_cnt_q <= hold_cnt_q - 1'b1;
    end
  end

  // reset_i covers the cycles before the first reload edge
  assign rst_o = reset_i | (hold_cnt_q != '0);

  // *********************************************************
  // checks
  // *********************************************************

  // the domain stays in reset at least one edge past reset_i
  a_rst_stretch : assert property (@(posedge ref_clk_i) reset_i |=> rst_o)
    else $error("safe_rstgen: rst_o low right after reset_i");

  // exact hold length once reset_i has gone away
  a_rst_hold_len : assert property (
    @(posedge ref_clk_i) disable iff (reset_i)
    $fell(reset_i) |-> rst_o [*`SAFE_RST_HOLD] ##1 !rst_o
  ) else $error("safe_rstgen: hold length differs from SAFE_RST_HOLD");

endmodule

`default_nettype wire

// ==== rtl/safe_pkg.sv ====
// Types shared by the safe domain blocks.
// The pad index in a config write is log2(SAFE_N_IO) bits, so SAFE_N_IO
// should be a power of two, or some index values name no pad.
`default_nettype none
`include "safe_params.svh"

package safe_pkg;

  // *********************************************************
  // pad source select
  // *********************************************************

  // which bank drives a pad
  // PAD_SRC_OFF parks the pad with out and oe low
  typedef enum logic [`SAFE_NBIT_PADMUX-1:0] {
    PAD_SRC_PERIO  = 'd0,
    PAD_SRC_APBIO  = 'd1,
    PAD_SRC_FPGAIO = 'd2,
    PAD_SRC_OFF    = 'd3
  } pad_src_e;

  // one write on the credit channel
  // valid costs the sender one credit per cycle
  typedef struct packed {
    logic                          valid;
    logic [$clog2(`SAFE_N_IO)-1:0] pad;
    pad_src_e                      sel;
  } padcfg_wr_t;

  // drive from one peripheral bank, bit i belongs to pad i
  typedef struct packed {
    logic [`SAFE_N_IO-1:0] out;
    logic [`SAFE_N_IO-1:0] oe;
  } pad_bank_t;

endpackage

`default_nettype wire

// ==== rtl/safe_params.svh ====
// Sizing constants for the always-on safe domain.
// Every bank is SAFE_N_IO bits wide, and pad i uses bit i of its bank.
// SAFE_PADCFG_CREDITS and SAFE_SLOW_DIV must both be at least 2.
// SAFE_RST_HOLD must be at least 1.
`ifndef SAFE_PARAMS_SVH
`define SAFE_PARAMS_SVH

// *********************************************************
// pad mux sizing
// *********************************************************

// number of chip pads, also the width of every peripheral bank
`define SAFE_N_IO 16

// bits per pad source select
`define SAFE_NBIT_PADMUX 2

// *********************************************************
// config channel and timing
// *********************************************************

// write queue depth, which is also the sender's credits after reset
`define SAFE_PADCFG_CREDITS 4

// ref clock edges the domain reset stays up after reset_i drops
`define SAFE_RST_HOLD 8

// ref cycles per slow clock half period
`define SAFE_SLOW_DIV 4

`endif
